/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f --top-module core_tb -o core_sim

./obj_dir/core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    exit 1
fi
exit 0

/* source/core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]             word_t;
    typedef logic [$clog2(`CORE_REG_NUM)-1:0]  reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    // encoding matches the older two-bit operand choice
    typedef enum logic [1:0] {
        from_reg      = 2'b00,
        from_ex       = 2'b01,
        from_mem_alu  = 2'b10,
        from_mem_load = 2'b11
    } fwd_sel_t;

    typedef enum logic [3:0] {
        cls_alu,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_ecall,
        cls_mret,
        cls_fence_i,
        cls_none
    } inst_class_t;

endpackage

/* source/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ****************************************
// datapath and storage sizes
// ****************************************

`define CORE_XLEN        32
`define CORE_REG_NUM     32
`define CORE_DMEM_WORDS  64

// ****************************************
// trap handling
// ****************************************

// ecall jumps here since mtvec is not writable in this core
`define CORE_MTVEC       32'h0000_0100

`endif

/* source/core_top.sv */
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     inst_valid,
    input  word_t    inst,
    input  word_t    inst_pc,
    output logic     stall,
    output logic     dnpc_flag,
    output word_t    dnpc,
    output logic     icache_clr,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    ex_bus_if  ex_bus ();
    mem_bus_if mem_bus ();

    word_t    ex_rs1;
    word_t    ex_rs2;
    word_t    ex_result;
    word_t    mem_rdata;
    word_t    mepc;
    logic     flush;
    logic     id_valid;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;

    decode_stage decode_i (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .stall      (stall),
        .flush      (flush),
        .wb_en      (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .id_valid   (id_valid),
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .ex         (ex_bus)
    );

    execute_stage execute_i (
        .clk       (clk),
        .rst       (rst),
        .ex        (ex_bus),
        .ex_rs1    (ex_rs1),
        .ex_rs2    (ex_rs2),
        .ex_result (ex_result),
        .mem       (mem_bus),
        .mepc      (mepc)
    );

    result_stage result_i (
        .clk       (clk),
        .rst       (rst),
        .mem       (mem_bus),
        .mem_rdata (mem_rdata),
        .wb_en     (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    pipe_control control_i (
        .ex         (ex_bus),
        .mem        (mem_bus),
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .id_valid   (id_valid),
        .ex_result  (ex_result),
        .mem_rdata  (mem_rdata),
        .mepc       (mepc),
        .ex_rs1     (ex_rs1),
        .ex_rs2     (ex_rs2),
        .stall      (stall),
        .flush      (flush),
        .dnpc_flag  (dnpc_flag),
        .icache_clr (icache_clr),
        .dnpc       (dnpc)
    );

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     inst_valid,
    input  word_t    inst,
    input  word_t    inst_pc,
    input  logic     stall,
    input  logic     flush,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output logic     id_valid,
    output reg_idx_t id_rs1,
    output reg_idx_t id_rs2,
    ex_bus_if.src    ex
);

    word_t       id_inst;
    word_t       id_pc;
    word_t       rf [`CORE_REG_NUM];
    inst_class_t cls;
    alu_op_t     op;
    word_t       imm;
    logic        use_rs1;
    logic        use_rs2;
    logic        writes_rd;
    reg_idx_t    rd;
    word_t       rs1_val;
    word_t       rs2_val;

    // ****************************************
    // ID register
    // ****************************************

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !flush) begin
            id_inst <= inst;
            id_pc   <= inst_pc;
        end
    end

    // ****************************************
    // decoder
    // ****************************************

    always_comb begin
        cls       = cls_none;
        op        = alu_add;
        imm       = '0;    // R-type keeps a zero immediate, execute relies on it
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        writes_rd = 1'b0;
        case (id_inst[6:0])
            7'b0110011: begin
                cls       = cls_alu;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                writes_rd = 1'b1;
                case (id_inst[14:12])
                    3'b000:  op = id_inst[30] ? alu_sub : alu_add;
                    3'b010:  op = alu_slt;
                    3'b100:  op = alu_xor;
                    3'b110:  op = alu_or;
                    3'b111:  op = alu_and;
                    default: begin
                        cls       = cls_none;
                        writes_rd = 1'b0;
                    end
                endcase
            end
            7'b0010011: begin
                if (id_inst[14:12] == 3'b000) begin    // addi only
                    cls       = cls_alu;
                    use_rs1   = 1'b1;
                    writes_rd = 1'b1;
                    imm       = {{20{id_inst[31]}}, id_inst[31:20]};
                end
            end
            7'b0110111: begin
                cls       = cls_alu;
                op        = alu_pass_b;
                writes_rd = 1'b1;
                imm       = {id_inst[31:12], 12'b0};
            end
            7'b0000011: begin
                cls       = cls_load;
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
                imm       = {{20{id_inst[31]}}, id_inst[31:20]};
            end
            7'b0100011: begin
                cls     = cls_store;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
            end
            7'b1100011: begin
                cls     = cls_branch;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = {{19{id_inst[31]}}, id_inst[31], id_inst[7],
                           id_inst[30:25], id_inst[11:8], 1'b0};
            end
            7'b1101111: begin
                cls       = cls_jal;
                writes_rd = 1'b1;
                imm       = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12],
                             id_inst[20], id_inst[30:21], 1'b0};
            end
            7'b1100111: begin
                cls       = cls_jalr;
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
                imm       = {{20{id_inst[31]}}, id_inst[31:20]};
            end
            7'b1110011: begin
                if (id_inst == 32'h0000_0073) cls = cls_ecall;
                if (id_inst == 32'h3020_0073) cls = cls_mret;
            end
            7'b0001111: begin
                if (id_inst[14:12] == 3'b001) cls = cls_fence_i;
            end
            default: cls = cls_none;
        endcase
    end

    // unused source fields read as x0 so they never match a destination
    assign id_rs1 = use_rs1 ? id_inst[19:15] : '0;
    assign id_rs2 = use_rs2 ? id_inst[24:20] : '0;
    assign rd     = writes_rd ? id_inst[11:7] : '0;

    // ****************************************
    // register file
    // ****************************************

    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != '0) begin
            rf[wb_rd] <= wb_data;
        end
    end

    // the MEM write lands at the same edge, so pass it straight through
    always_comb begin
        rs1_val = rf[id_rs1];
        rs2_val = rf[id_rs2];
        if (wb_en && wb_rd == id_rs1) rs1_val = wb_data;
        if (wb_en && wb_rd == id_rs2) rs2_val = wb_data;
        if (id_rs1 == '0) rs1_val = '0;
        if (id_rs2 == '0) rs2_val = '0;
    end

    // ****************************************
    // ID/EX register
    // ****************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= id_valid && !stall && !flush;    // bubble on stall or flush
        end
    end

    always_ff @(posedge clk) begin
        ex.pc      <= id_pc;
        ex.imm     <= imm;
        ex.cls     <= cls;
        ex.op      <= op;
        ex.bne     <= id_inst[12];
        ex.rs1     <= id_rs1;
        ex.rs2     <= id_rs2;
        ex.rd      <= rd;
        ex.reg_wen <= rd != '0;
        ex.rs1_val <= rs1_val;
        ex.rs2_val <= rs2_val;
    end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    ex_bus_if.dst  ex,
    input  word_t  ex_rs1,
    input  word_t  ex_rs2,
    output word_t  ex_result,
    mem_bus_if.src mem,
    output word_t  mepc
);

    word_t op_b;
    word_t alu_out;
    logic  taken;

    // addi and R-type with x0 both end up on the immediate, which is zero for R-type
    assign op_b = (ex.cls == cls_alu && ex.rs2 != '0) ? ex_rs2 : ex.imm;

    always_comb begin
        case (ex.op)
            alu_add: alu_out = ex_rs1 + op_b;
            alu_sub: alu_out = ex_rs1 - op_b;
            alu_and: alu_out = ex_rs1 & op_b;
            alu_or:  alu_out = ex_rs1 | op_b;
            alu_xor: alu_out = ex_rs1 ^ op_b;
            alu_slt: alu_out = {{(`CORE_XLEN-1){1'b0}}, $signed(ex_rs1) < $signed(op_b)};
            default: alu_out = op_b;    // lui
        endcase
    end

    assign taken = (ex_rs1 == ex_rs2) ^ ex.bne;

    always_comb begin
        case (ex.cls)
            cls_jal, cls_jalr: ex_result = ex.pc + word_t'(4);    // link address
            cls_branch:        ex_result = {{(`CORE_XLEN-1){1'b0}}, taken};
            default:           ex_result = alu_out;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc <= '0;
        end else if (ex.valid && ex.cls == cls_ecall) begin
            mepc <= ex.pc;
        end
    end

    // ****************************************
    // EX/MEM register
    // ****************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            mem.valid <= 1'b0;
        end else begin
            mem.valid <= ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        mem.rd         <= ex.rd;
        mem.reg_wen    <= ex.reg_wen;
        mem.mem_ren    <= ex.cls == cls_load;
        mem.mem_wen    <= ex.cls == cls_store;
        mem.alu_result <= ex_result;
        mem.store_data <= ex_rs2;
    end

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import core_pkg::*; (
    ex_bus_if.dst    ex,
    mem_bus_if.dst   mem,
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  logic     id_valid,
    output fwd_sel_t rs1_sel,
    output fwd_sel_t rs2_sel,
    output logic     stall
);

    logic     mem_writes;
    fwd_sel_t mem_src;
    logic     load_in_ex;

    assign mem_writes = mem.valid && mem.reg_wen && mem.rd != '0;
    assign mem_src    = mem.mem_ren ? from_mem_load : from_mem_alu;

    // older results already sit in the register file or its write port
    assign rs1_sel = (mem_writes && mem.rd == ex.rs1) ? mem_src : from_reg;
    assign rs2_sel = (mem_writes && mem.rd == ex.rs2) ? mem_src : from_reg;

    // a load in EX has only its address ready, so hold its consumer in ID
    assign load_in_ex = ex.valid && ex.cls == cls_load && ex.reg_wen;
    assign stall      = id_valid && load_in_ex && (ex.rd == id_rs1 || ex.rd == id_rs2);

endmodule

/* source/pipe_control.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module pipe_control import core_pkg::*; (
    ex_bus_if.dst    ex,
    mem_bus_if.dst   mem,
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  logic     id_valid,
    input  word_t    ex_result,
    input  word_t    mem_rdata,
    input  word_t    mepc,
    output word_t    ex_rs1,
    output word_t    ex_rs2,
    output logic     stall,
    output logic     flush,
    output logic     dnpc_flag,
    output logic     icache_clr,
    output word_t    dnpc
);

    fwd_sel_t rs1_sel;
    fwd_sel_t rs2_sel;
    logic     redirect;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t alu_val,
                                      word_t load_val);
        case (sel)
            from_mem_alu:  return alu_val;
            from_mem_load: return load_val;
            default:       return reg_val;
        endcase
    endfunction

    hazard_unit hazard_i (
        .ex       (ex),
        .mem      (mem),
        .id_rs1   (id_rs1),
        .id_rs2   (id_rs2),
        .id_valid (id_valid),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .stall    (stall)
    );

    assign ex_rs1 = fwd_mux(rs1_sel, ex.rs1_val, mem.alu_result, mem_rdata);
    assign ex_rs2 = fwd_mux(rs2_sel, ex.rs2_val, mem.alu_result, mem_rdata);

    // ****************************************
    // redirect
    // ****************************************

    always_comb begin
        case (ex.cls)
            cls_jal, cls_jalr, cls_ecall, cls_mret, cls_fence_i: redirect = ex.valid;
            cls_branch: redirect = ex.valid && ex_result[0];    // bit 0 is the taken flag
            default:    redirect = 1'b0;
        endcase
    end

    assign dnpc_flag  = redirect;
    assign flush      = redirect;
    assign icache_clr = ex.valid && ex.cls == cls_fence_i;

    always_comb begin
        case (ex.cls)
            cls_jalr:  dnpc = (ex_rs1 + ex.imm) & ~word_t'(1);
            cls_mret:  dnpc = mepc;
            cls_ecall: dnpc = `CORE_MTVEC;
            cls_jal, cls_branch: dnpc = ex.pc + ex.imm;
            default:   dnpc = ex.pc + word_t'(4);    // fence.i refetches the next word
        endcase
    end

endmodule

/* source/pipe_if.sv */
`timescale 1ns/1ps

// contents of the ID/EX register
interface ex_bus_if import core_pkg::*; ();
    logic        valid;
    word_t       pc;
    word_t       imm;
    inst_class_t cls;
    alu_op_t     op;
    logic        bne;      // branch when not equal
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    logic        reg_wen;
    word_t       rs1_val;
    word_t       rs2_val;

    modport src (output valid, pc, imm, cls, op, bne, rs1, rs2, rd, reg_wen, rs1_val, rs2_val);
    modport dst (input  valid, pc, imm, cls, op, bne, rs1, rs2, rd, reg_wen, rs1_val, rs2_val);
endinterface

// contents of the EX/MEM register
interface mem_bus_if import core_pkg::*; ();
    logic     valid;
    reg_idx_t rd;
    logic     reg_wen;
    logic     mem_ren;
    logic     mem_wen;
    word_t    alu_result;
    word_t    store_data;

    modport src (output valid, rd, reg_wen, mem_ren, mem_wen, alu_result, store_data);
    modport dst (input  valid, rd, reg_wen, mem_ren, mem_wen, alu_result, store_data);
endinterface

/* source/result_stage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module result_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    mem_bus_if.dst   mem,
    output word_t    mem_rdata,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    localparam int addr_w = $clog2(`CORE_DMEM_WORDS);

    word_t             dmem [`CORE_DMEM_WORDS];
    logic [addr_w-1:0] addr;

    // word addressed, byte offset bits dropped
    assign addr      = mem.alu_result[addr_w+1:2];
    assign mem_rdata = dmem[addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem.valid && mem.mem_wen) begin
            dmem[addr] <= mem.store_data;
        end
    end

    // ****************************************
    // writeback
    // ****************************************

    assign wb_en   = mem.valid && mem.reg_wen;
    assign wb_rd   = mem.rd;
    assign wb_data = mem.mem_ren ? mem_rdata : mem.alu_result;

endmodule

/* sources.f */
+incdir+source
source/core_pkg.sv
source/pipe_if.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/hazard_unit.sv
source/pipe_control.sv
source/core_top.sv
tb/core_tb.sv

/* tb/core_stim.txt */
# P addr word : program word | E addr : fetch stops here | T name : new test
# W rd value : expected writeback | R target clr : expected redirect, icache clear bit
P 00 00500093
P 04 FFD00113
P 08 123451B7
P 0C 00208233
P 10 402082B3
P 14 0020F333
P 18 0020E3B3
P 1C 0020C433
P 20 001124B3
P 24 00118013
P 28 00100513
P 2C 00A50533
P 30 00A50533
P 34 00A505B3
P 38 40A58633
P 3C 04000693
P 40 00C6A023
P 44 0006A703
P 48 00E707B3
P 4C 00108463
P 50 06300813
P 54 00109463
P 58 00700813
P 5C 00209463
P 60 06300813
P 64 00C008EF
P 68 06300813
P 6C 06300813
P 70 08000913
P 74 008909E7
P 88 00000A93
P 8C 00000073
P 90 0000100F
P 94 03300B13
P 100 000A9863
P 104 00100A93
P 108 30200073
P 110 F81FF06F
E 98
T alu_basic
W 1 00000005
W 2 FFFFFFFD
W 3 12345000
W 4 00000002
W 5 00000008
W 6 00000005
W 7 FFFFFFFD
W 8 FFFFFFF8
W 9 00000001
T forwarding
W 10 00000001
W 10 00000002
W 10 00000004
W 11 00000008
W 12 00000004
T load_use
W 13 00000040
W 14 00000004
W 15 00000008
T branch_jump
W 16 00000007
W 17 00000068
W 18 00000080
W 19 00000078
R 54 0
R 64 0
R 70 0
R 88 0
T ecall_mret
W 21 00000000
W 21 00000001
R 100 0
R 8C 0
R 100 0
R 110 0
R 90 0
T fence_i
W 22 00000033
R 94 1

/* tb/core_tb.sv */
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    logic     clk;
    logic     rst;
    logic     inst_valid;
    word_t    inst;
    word_t    inst_pc;
    logic     stall;
    logic     dnpc_flag;
    word_t    dnpc;
    logic     icache_clr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    word_t    prog [word_t];
    word_t    end_pc;
    word_t    fetch_pc;
    logic     loaded;
    logic     stall_q;
    int       errors;
    int       test_errs;
    int       stall_errs;

    // expected records grouped per test by count
    string    test_name [$];
    int       test_w_cnt [$];
    int       test_r_cnt [$];
    reg_idx_t exp_w_rd [$];
    word_t    exp_w_val [$];
    word_t    exp_r_pc [$];
    logic     exp_r_clr [$];

    // records seen at the DUT outputs
    reg_idx_t got_w_rd [$];
    word_t    got_w_val [$];
    word_t    got_r_pc [$];
    logic     got_r_clr [$];

    core_top core_i (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .stall      (stall),
        .dnpc_flag  (dnpc_flag),
        .dnpc       (dnpc),
        .icache_clr (icache_clr),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // unlisted addresses hold an addi to x0 whose immediate folds the address
    function automatic word_t fill_word(word_t a);
        logic [11:0] f;
        f = a[11:0] ^ a[23:12] ^ {4'b0, a[31:24]};
        return {f, 5'd0, 3'd0, 5'd0, 7'b0010011};
    endfunction

    function automatic word_t image_word(word_t a);
        if (prog.exists(a)) return prog[a];
        return fill_word(a);
    endfunction

    task automatic check_word(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic check_reg(string name, reg_idx_t expected, reg_idx_t actual);
        if (expected !== actual) begin
            $display("Fail %s expected x%0d actual x%0d", name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (expected !== actual) begin
            $display("Fail %s expected %b actual %b", name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic load_stim(output bit ok);
        int    fd;
        int    n;
        string line;
        string tag;
        string name;
        word_t a;
        word_t b;
        fd = $fopen("tb/core_stim.txt", "r");
        ok = fd != 0;
        if (fd == 0) begin
            $display("cannot open the stimulus file tb/core_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                tag = "";
                n = $sscanf(line, "%s", tag);
                case (tag)
                    "P": begin
                        n = $sscanf(line, "%s %h %h", tag, a, b);
                        prog[a] = b;
                    end
                    "E": n = $sscanf(line, "%s %h", tag, end_pc);
                    "T": begin
                        n = $sscanf(line, "%s %s", tag, name);
                        test_name.push_back(name);
                        test_w_cnt.push_back(0);
                        test_r_cnt.push_back(0);
                    end
                    "W": begin
                        n = $sscanf(line, "%s %d %h", tag, a, b);
                        exp_w_rd.push_back(reg_idx_t'(a));
                        exp_w_val.push_back(b);
                        test_w_cnt[test_w_cnt.size()-1]++;
                    end
                    "R": begin
                        n = $sscanf(line, "%s %h %d", tag, a, b);
                        exp_r_pc.push_back(a);
                        exp_r_clr.push_back(b[0]);
                        test_r_cnt[test_r_cnt.size()-1]++;
                    end
                    default: ;    // comments and blank lines
                endcase
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_records(output int n_ok, output int n_bad);
        int wi;
        int ri;
        wi = 0;
        ri = 0;
        n_ok = 0;
        n_bad = 0;
        foreach (test_name[t]) begin
            test_errs = 0;
            for (int k = 0; k < test_w_cnt[t]; k++) begin
                check_reg(test_name[t], exp_w_rd[wi], got_w_rd[wi]);
                check_word(test_name[t], exp_w_val[wi], got_w_val[wi]);
                wi++;
            end
            for (int k = 0; k < test_r_cnt[t]; k++) begin
                check_word(test_name[t], exp_r_pc[ri], got_r_pc[ri]);
                check_flag(test_name[t], exp_r_clr[ri], got_r_clr[ri]);
                ri++;
            end
            if (test_errs == 0) begin
                $display("%s: ok", test_name[t]);
                n_ok++;
            end else begin
                $display("%s: %0d mismatches", test_name[t], test_errs);
                n_bad++;
            end
            errors += test_errs;
        end
        if (got_w_rd.size() > wi || got_r_pc.size() > ri) begin
            $display("extra writebacks or redirects seen after the last expected one");
            errors++;
        end
    endtask

    // ****************************************
    // fetch model and monitors
    // ****************************************

    initial begin
        void'($urandom(76287));
        forever begin
            @(posedge clk);
            if (rst) begin
                fetch_pc = '0;
                inst_valid <= 1'b0;
            end else if (!(stall && !dnpc_flag)) begin    // a stall holds the slot
                if (dnpc_flag) fetch_pc = dnpc;
                else if (inst_valid) fetch_pc = inst_pc + 4;
                inst_pc <= fetch_pc;
                inst    <= image_word(fetch_pc);
                inst_valid <= fetch_pc != end_pc && ($urandom % 4) != 0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && wb_valid) begin
            got_w_rd.push_back(wb_rd);
            got_w_val.push_back(wb_data);
        end
        if (!rst && dnpc_flag) begin
            got_r_pc.push_back(dnpc);
            got_r_clr.push_back(icache_clr);
        end
        // a load-use stall lasts a single cycle before its bubble clears it
        if (!rst && stall && stall_q) begin
            $display("stall stayed high for more than one cycle at time %0t", $time);
            stall_errs++;
        end
        stall_q = !rst && stall;
    end

    initial begin
        int limit;
        wait (loaded);
        limit = 20 * prog.size() + 100;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, the program never reached its end", limit);
        $display("test failed");
        $finish;
    end

    // ****************************************
    // main sequence
    // ****************************************

    initial begin
        int n_ok;
        int n_bad;
        bit stim_ok;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        fetch_pc   = '0;
        end_pc     = '0;
        stall_q    = 1'b0;
        errors     = 0;
        stall_errs = 0;
        loaded     = 1'b0;
        load_stim(stim_ok);
        if (!stim_ok) begin
            $display("test failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            // the run ends once every expected record has come out of the DUT
            while (got_w_rd.size() < exp_w_rd.size() ||
                   got_r_pc.size() < exp_r_pc.size()) begin
                @(negedge clk);
            end
            compare_records(n_ok, n_bad);
            errors += stall_errs;
            $display("tests: %0d ok, %0d failed", n_ok, n_bad);
            if (errors == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule
